/* verilog/decoding_graph_pkg.sv */
package decoding_graph_pkg;

    // lattice size
    localparam int grid_width_x = 4;   // rows per round
    localparam int grid_width_z = 3;   // columns per round
    localparam int round_count = 3;    // one layer per measurement round

    localparam int pu_count_per_round = grid_width_x * grid_width_z;
    localparam int pu_count = pu_count_per_round * round_count;

    // coordinate field widths inside a node address
    localparam int x_bit_width = $clog2(grid_width_x);
    localparam int z_bit_width = $clog2(grid_width_z);
    localparam int u_bit_width = $clog2(round_count);
    localparam int address_width = u_bit_width + x_bit_width + z_bit_width;

    // edge growth
    localparam int link_weight = 2;    // growth units until an edge is fully grown
    localparam int growth_width = $clog2(link_weight + 1);

    localparam int neighbor_count = 6;

    // u in the top bits, then x, then z
    // so numeric order is round first, then row, then column
    typedef logic [address_width-1:0] node_address_t;

    typedef enum logic [1:0] {
        stage_idle,
        stage_load,    // shift one round into the lattice
        stage_grow,
        stage_merge
    } stage_e;

    // slot order of the neighbor vectors
    typedef enum logic [2:0] {
        dir_north,     // x - 1
        dir_south,     // x + 1
        dir_west,      // z - 1
        dir_east,      // z + 1
        dir_down,      // u - 1
        dir_up         // u + 1
    } direction_e;

    function automatic node_address_t make_node_address(int u, int x, int z);
        return {u[u_bit_width-1:0], x[x_bit_width-1:0], z[z_bit_width-1:0]};
    endfunction

endpackage

/* verilog/processing_unit.sv */
`timescale 1ns/1ps

module processing_unit import decoding_graph_pkg::*; #(
    parameter node_address_t node_address = '0
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  stage_e                                stage_i,
    input  logic                                  measurement_i,
    output logic                                  measurement_o,
    input  logic [neighbor_count-1:0]             neighbor_fully_grown_i,
    input  logic [neighbor_count*address_width-1:0] neighbor_roots_i,
    output logic                                  defect_o,
    output node_address_t                         root_o,
    output logic                                  busy_o
);

    logic          measurement_q;
    node_address_t root_q;
    node_address_t merged_root;   // smallest root seen across grown edges
    logic          busy_q;

    // measurement bit, also the defect flag of this node
    always_ff @(posedge clk) begin
        if (reset) begin
            measurement_q <= 1'b0;
        end else if (stage_i == stage_load) begin
            measurement_q <= measurement_i;
        end
    end

    // running minimum over own root and every fully grown neighbor
    always_comb begin
        merged_root = root_q;
        for (int d = 0; d < neighbor_count; d++) begin
            if (neighbor_fully_grown_i[d] &&
                (neighbor_roots_i[d*address_width +: address_width] < merged_root)) begin
                merged_root = neighbor_roots_i[d*address_width +: address_width];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            root_q <= node_address;
        end else begin
            case (stage_i)
                stage_load:  root_q <= node_address;   // fresh round, every node alone
                stage_merge: root_q <= merged_root;
                default:     root_q <= root_q;
            endcase
        end
    end

    // busy marks a root that moved in the last merge cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q <= 1'b0;
        end else begin
            busy_q <= (stage_i == stage_merge) && (merged_root != root_q);
        end
    end

    assign measurement_o = measurement_q;   // feeds the node one layer down
    assign defect_o = measurement_q;
    assign root_o = root_q;
    assign busy_o = busy_q;

endmodule

/* verilog/neighbor_link.sv */
`timescale 1ns/1ps

module neighbor_link import decoding_graph_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  stage_e stage_i,
    input  logic   a_defect_i,
    input  logic   b_defect_i,
    output logic   fully_grown_o
);

    localparam logic [growth_width-1:0] weight_full = growth_width'(link_weight);
    localparam logic [growth_width:0] weight_ext = (growth_width + 1)'(link_weight);

    logic [growth_width-1:0] growth_q;
    logic [growth_width:0]   growth_sum;   // one extra bit so the add cannot wrap

    // each defect endpoint adds one unit per grow cycle
    assign growth_sum = {1'b0, growth_q}
                      + {{growth_width{1'b0}}, a_defect_i}
                      + {{growth_width{1'b0}}, b_defect_i};

    always_ff @(posedge clk) begin
        if (reset) begin
            growth_q <= '0;
        end else begin
            case (stage_i)
                stage_load: growth_q <= '0;
                stage_grow: begin
                    if (growth_sum >= weight_ext) begin
                        growth_q <= weight_full;   // saturate
                    end else begin
                        growth_q <= growth_sum[growth_width-1:0];
                    end
                end
                default: growth_q <= growth_q;
            endcase
        end
    end

    // edge joins its two clusters once the counter is full
    assign fully_grown_o = (growth_q == weight_full);

endmodule

/* verilog/decoding_graph.sv */
`timescale 1ns/1ps

module decoding_graph import decoding_graph_pkg::*; (
    input  logic                            clk,
    input  logic                            reset,
    input  stage_e                          stage_i,
    input  logic [pu_count_per_round-1:0]   measurements_i,
    output logic [pu_count*address_width-1:0] roots_o,
    output logic [pu_count-1:0]             busy_o
);

    // per node, index u*pu_count_per_round + x*grid_width_z + z
    logic [pu_count-1:0] measurement_in;
    logic [pu_count-1:0] measurement_out;
    logic [pu_count-1:0] defect;

    // edge state, owned by the lower-index endpoint
    // bits with no edge in that direction stay low
    logic [pu_count-1:0] ns_grown;   // node to its south neighbor
    logic [pu_count-1:0] ew_grown;   // node to its east neighbor
    logic [pu_count-1:0] ud_grown;   // node to the node above

    for (genvar u = 0; u < round_count; u++) begin : g_pu_u
        for (genvar x = 0; x < grid_width_x; x++) begin : g_pu_x
            for (genvar z = 0; z < grid_width_z; z++) begin : g_pu_z
                localparam int n = u*pu_count_per_round + x*grid_width_z + z;
                // off-lattice directions fall back to the node itself
                localparam int n_north = (x > 0) ? n - grid_width_z : n;
                localparam int n_south = (x < grid_width_x - 1) ? n + grid_width_z : n;
                localparam int n_west = (z > 0) ? n - 1 : n;
                localparam int n_east = (z < grid_width_z - 1) ? n + 1 : n;
                localparam int n_down = (u > 0) ? n - pu_count_per_round : n;
                localparam int n_up = (u < round_count - 1) ? n + pu_count_per_round : n;

                logic [neighbor_count-1:0]               nb_grown;
                logic [neighbor_count*address_width-1:0] nb_roots;

                assign nb_grown[dir_north] = (x > 0) && ns_grown[n_north];
                assign nb_grown[dir_south] = ns_grown[n];
                assign nb_grown[dir_west] = (z > 0) && ew_grown[n_west];
                assign nb_grown[dir_east] = ew_grown[n];
                assign nb_grown[dir_down] = (u > 0) && ud_grown[n_down];
                assign nb_grown[dir_up] = ud_grown[n];

                assign nb_roots[dir_north*address_width +: address_width] =
                    roots_o[n_north*address_width +: address_width];
                assign nb_roots[dir_south*address_width +: address_width] =
                    roots_o[n_south*address_width +: address_width];
                assign nb_roots[dir_west*address_width +: address_width] =
                    roots_o[n_west*address_width +: address_width];
                assign nb_roots[dir_east*address_width +: address_width] =
                    roots_o[n_east*address_width +: address_width];
                assign nb_roots[dir_down*address_width +: address_width] =
                    roots_o[n_down*address_width +: address_width];
                assign nb_roots[dir_up*address_width +: address_width] =
                    roots_o[n_up*address_width +: address_width];

                // measurements enter at the top layer and shift down
                if (u == round_count - 1) begin : g_top
                    assign measurement_in[n] = measurements_i[x*grid_width_z + z];
                end else begin : g_chain
                    assign measurement_in[n] = measurement_out[n + pu_count_per_round];
                end

                processing_unit #(
                    .node_address(make_node_address(u, x, z))
                ) pu (
                    .clk                    (clk),
                    .reset                  (reset),
                    .stage_i                (stage_i),
                    .measurement_i          (measurement_in[n]),
                    .measurement_o          (measurement_out[n]),
                    .neighbor_fully_grown_i (nb_grown),
                    .neighbor_roots_i       (nb_roots),
                    .defect_o               (defect[n]),
                    .root_o                 (roots_o[n*address_width +: address_width]),
                    .busy_o                 (busy_o[n])
                );
            end
        end
    end

    for (genvar u = 0; u < round_count; u++) begin : g_link_u
        for (genvar x = 0; x < grid_width_x; x++) begin : g_link_x
            for (genvar z = 0; z < grid_width_z; z++) begin : g_link_z
                localparam int n = u*pu_count_per_round + x*grid_width_z + z;

                if (x < grid_width_x - 1) begin : g_ns
                    neighbor_link ns_link (
                        .clk           (clk),
                        .reset         (reset),
                        .stage_i       (stage_i),
                        .a_defect_i    (defect[n]),
                        .b_defect_i    (defect[n + grid_width_z]),
                        .fully_grown_o (ns_grown[n])
                    );
                end else begin : g_ns_open
                    assign ns_grown[n] = 1'b0;
                end

                if (z < grid_width_z - 1) begin : g_ew
                    neighbor_link ew_link (
                        .clk           (clk),
                        .reset         (reset),
                        .stage_i       (stage_i),
                        .a_defect_i    (defect[n]),
                        .b_defect_i    (defect[n + 1]),
                        .fully_grown_o (ew_grown[n])
                    );
                end else begin : g_ew_open
                    assign ew_grown[n] = 1'b0;
                end

                if (u < round_count - 1) begin : g_ud
                    neighbor_link ud_link (
                        .clk           (clk),
                        .reset         (reset),
                        .stage_i       (stage_i),
                        .a_defect_i    (defect[n]),
                        .b_defect_i    (defect[n + pu_count_per_round]),
                        .fully_grown_o (ud_grown[n])
                    );
                end else begin : g_ud_open
                    assign ud_grown[n] = 1'b0;   // top layer has nothing above
                end
            end
        end
    end

endmodule

/* sim/decoding_graph_assertions.sv */
`timescale 1ns/1ps

module decoding_graph_assertions import decoding_graph_pkg::*; (
    input logic                             clk,
    input logic                             reset,
    input stage_e                           stage_i,
    input logic [pu_count*address_width-1:0] roots_i,
    input logic [pu_count-1:0]              busy_i
);

    // busy can only follow a merge cycle
    assert property (@(posedge clk) disable iff (reset)
        ($past(stage_i) != stage_merge) |-> (busy_i == '0))
        else $error("busy_o high after a cycle without merge");

    // roots hold unless the last cycle was a load or a merge
    assert property (@(posedge clk) disable iff (reset)
        (($past(stage_i) != stage_load) && ($past(stage_i) != stage_merge))
            |-> (roots_i == $past(roots_i)))
        else $error("roots_o changed outside load and merge");

    for (genvar n = 0; n < pu_count; n++) begin : g_node
        assert property (@(posedge clk) disable iff (reset)
            ($past(stage_i) == stage_merge) |->
                (roots_i[n*address_width +: address_width] <=
                 $past(roots_i[n*address_width +: address_width])))
            else $error("root of node %0d grew during merge", n);
    end

endmodule

/* sim/decoding_graph_checker.sv */
`timescale 1ns/1ps

module decoding_graph_checker import decoding_graph_pkg::*; (
    input  logic                             clk,
    input  logic                             reset,
    input  stage_e                           stage_i,
    input  logic [pu_count_per_round-1:0]    measurements_i,
    input  logic [pu_count*address_width-1:0] roots_i,
    input  logic [pu_count-1:0]              busy_i,
    input  logic                             compare_i,
    output int                               error_count_o,
    output int                               check_count_o
);

    logic [pu_count-1:0]               layers_q;      // model of the loaded measurement bits
    int                                grow_count_q;  // grow cycles since the last load
    logic [pu_count*address_width-1:0] expected;

    // u above x above z, each field packed at its own width
    function automatic logic [address_width-1:0] address_of(input int u, input int x, input int z);
        return address_width'((u << (x_bit_width + z_bit_width)) | (x << z_bit_width) | z);
    endfunction

    function automatic bit edge_grown(input logic a, input logic b, input int grow_cycles);
        return ((int'(a) + int'(b)) * grow_cycles) >= link_weight;
    endfunction

    // label every connected component with its smallest node address
    function automatic logic [pu_count*address_width-1:0] expected_roots(
        input logic [pu_count-1:0] layers,
        input int                  grow_cycles
    );
        logic [address_width-1:0]          label [pu_count];
        logic [pu_count-1:0]               grown [3];   // south, east, up
        logic [pu_count*address_width-1:0] result;
        int n;
        int m;
        int step;
        bit changed;
        for (int u = 0; u < round_count; u++) begin
            for (int x = 0; x < grid_width_x; x++) begin
                for (int z = 0; z < grid_width_z; z++) begin
                    n = u*pu_count_per_round + x*grid_width_z + z;
                    label[n] = address_of(u, x, z);
                    grown[0][n] = 1'b0;
                    grown[1][n] = 1'b0;
                    grown[2][n] = 1'b0;
                    if (x < grid_width_x - 1)
                        grown[0][n] = edge_grown(layers[n], layers[n+grid_width_z], grow_cycles);
                    if (z < grid_width_z - 1)
                        grown[1][n] = edge_grown(layers[n], layers[n+1], grow_cycles);
                    if (u < round_count - 1)
                        grown[2][n] = edge_grown(layers[n], layers[n+pu_count_per_round],
                                                 grow_cycles);
                end
            end
        end
        changed = 1'b1;
        while (changed) begin
            changed = 1'b0;
            for (n = 0; n < pu_count; n++) begin
                for (int d = 0; d < 3; d++) begin
                    step = (d == 0) ? grid_width_z : ((d == 1) ? 1 : pu_count_per_round);
                    if (grown[d][n]) begin
                        m = n + step;
                        if (label[m] < label[n]) begin
                            label[n] = label[m];
                            changed = 1'b1;
                        end else if (label[n] < label[m]) begin
                            label[m] = label[n];
                            changed = 1'b1;
                        end
                    end
                end
            end
        end
        for (n = 0; n < pu_count; n++) begin
            result[n*address_width +: address_width] = label[n];
        end
        return result;
    endfunction

    // loads shift every layer down and fill the top one
    always_ff @(posedge clk) begin
        if (reset) begin
            layers_q <= '0;
            grow_count_q <= 0;
        end else if (stage_i == stage_load) begin
            layers_q <= {measurements_i, layers_q[pu_count-1:pu_count_per_round]};
            grow_count_q <= 0;
        end else if (stage_i == stage_grow) begin
            grow_count_q <= grow_count_q + 1;
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            error_count_o = 0;
            check_count_o = 0;
        end else if (compare_i) begin
            expected = expected_roots(layers_q, grow_count_q);
            for (int n = 0; n < pu_count; n++) begin
                check_count_o = check_count_o + 1;
                if (roots_i[n*address_width +: address_width] !=
                    expected[n*address_width +: address_width]) begin
                    error_count_o = error_count_o + 1;
                    $display("ERROR roots_o node %0d: expected %h, actual %h", n,
                             expected[n*address_width +: address_width],
                             roots_i[n*address_width +: address_width]);
                end
            end
            check_count_o = check_count_o + 1;
            if (busy_i != '0) begin
                error_count_o = error_count_o + 1;
                $display("ERROR busy_o: expected %h, actual %h", {pu_count{1'b0}}, busy_i);
            end
        end
    end

endmodule

/* sim/tb_decoding_graph.sv */
`timescale 1ns/1ps

module tb_decoding_graph import decoding_graph_pkg::*; ();

    localparam int merge_timeout = 64;   // cycles

    logic                             clk;
    logic                             reset;
    stage_e                           stage;
    logic [pu_count_per_round-1:0]    measurements;
    logic [pu_count*address_width-1:0] roots_o;
    logic [pu_count-1:0]              busy_o;
    logic                             compare;
    int                               error_count;
    int                               check_count;
    int                               timeout_count;
    int                               failures_seen;
    int                               tests_run;
    int                               tests_failed;
    int                               grow_cycles;
    integer                           seed;

    decoding_graph dut0 (
        .clk            (clk),
        .reset          (reset),
        .stage_i        (stage),
        .measurements_i (measurements),
        .roots_o        (roots_o),
        .busy_o         (busy_o)
    );

    decoding_graph_checker check0 (
        .clk            (clk),
        .reset          (reset),
        .stage_i        (stage),
        .measurements_i (measurements),
        .roots_i        (roots_o),
        .busy_i         (busy_o),
        .compare_i      (compare),
        .error_count_o  (error_count),
        .check_count_o  (check_count)
    );

    bind decoding_graph decoding_graph_assertions assert0 (
        .clk     (clk),
        .reset   (reset),
        .stage_i (stage_i),
        .roots_i (roots_o),
        .busy_i  (busy_o)
    );

    always #5 clk = ~clk;

    // every task starts and ends 1 ns after a rising edge
    task automatic load_round(input logic [pu_count_per_round-1:0] row);
        stage = stage_load;
        measurements = row;
        @(posedge clk);
        #1;
        stage = stage_idle;
        measurements = '0;
    endtask

    task automatic grow_for(input int cycles);
        stage = stage_grow;
        repeat (cycles) begin
            @(posedge clk);
            #1;
        end
        stage = stage_idle;
    endtask

    task automatic merge_until_settled();
        int cycles;
        bit settled;
        cycles = 0;
        settled = 1'b0;
        stage = stage_merge;
        while (!settled && cycles < merge_timeout) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles >= 2 && busy_o == '0) settled = 1'b1;   // no root moved last cycle
        end
        stage = stage_idle;
        if (!settled) begin
            timeout_count++;
            $display("merge did not settle within %0d cycles", merge_timeout);
        end
    endtask

    task automatic compare_roots();
        compare = 1'b1;
        @(posedge clk);
        #1;
        compare = 1'b0;
    endtask

    task automatic report_test(input int number, input string name);
        int failures_now;
        failures_now = error_count + timeout_count;
        tests_run++;
        if (failures_now == failures_seen) begin
            $display("test %0d %s: ok", number, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d failures", number, name, failures_now - failures_seen);
        end
        failures_seen = failures_now;
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        stage = stage_idle;
        measurements = '0;
        compare = 1'b0;
        timeout_count = 0;
        failures_seen = 0;
        tests_run = 0;
        tests_failed = 0;
        seed = 32'h1786;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        compare_roots();
        report_test(1, "reset state");

        // grow a full lattice, then reload it and merge without growth
        repeat (round_count) load_round('1);
        grow_for(2);
        repeat (round_count) load_round('1);
        merge_until_settled();
        compare_roots();
        report_test(2, "load clears growth");

        // nodes (x0,z0) and (x0,z1) side by side, (x3,z2) alone
        load_round(12'h803);
        load_round(12'h000);
        load_round(12'h000);
        grow_for(1);
        merge_until_settled();
        compare_roots();
        report_test(3, "adjacent defects");

        load_round(12'h001);
        load_round(12'h000);
        load_round(12'h000);
        grow_for(1);
        merge_until_settled();
        compare_roots();   // still separate
        grow_for(1);
        merge_until_settled();
        compare_roots();
        report_test(4, "single defect growth");

        repeat (40) begin
            repeat (round_count) load_round(pu_count_per_round'($random(seed)));
            grow_cycles = $unsigned($random(seed)) % 4;
            grow_for(grow_cycles);
            merge_until_settled();
            compare_roots();
        end
        report_test(5, "random lattices");

        repeat (round_count) load_round(pu_count_per_round'($random(seed)));
        grow_for(1);
        merge_until_settled();
        compare_roots();
        report_test(6, "reload after merge");

        $display("tests %0d, failed %0d, checks %0d, errors %0d, timeouts %0d",
                 tests_run, tests_failed, check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* decoding_graph.f */
verilog/decoding_graph_pkg.sv
verilog/processing_unit.sv
verilog/neighbor_link.sv
verilog/decoding_graph.sv
sim/decoding_graph_assertions.sv
sim/decoding_graph_checker.sv
sim/tb_decoding_graph.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the decoding graph testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_decoding_graph \
    -f decoding_graph.f \
    -o sim_decoding_graph
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_decoding_graph)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1
